//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mini_core_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
FAIL_MSG  := *** TEST FAILED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+include
design/mini_core_isa_pkg.sv
design/mini_core_pipe_pkg.sv
design/mini_core_alu.sv
design/mini_core_exe.sv
design/mini_core_rf.sv
design/mini_core_ctrl.sv
design/mini_core.sv
verification/mini_core_tb.sv

//--- design/mini_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "mini_core_defines.svh"

module mini_core (
    input  wire logic                         Clock,
    input  wire logic                         rstN,
    input  wire logic                         InstValidQ101H,
    input  wire mini_core_isa_pkg::t_instr    InstructionQ101H,
    output var  mini_core_pipe_pkg::t_wb_q102 Wb
);

    mini_core_pipe_pkg::t_ctrl_rf  ctrlRf;
    mini_core_pipe_pkg::t_ctrl_alu ctrlAlu;
    logic [`MINI_CORE_XLEN-1:0]    regRdData1Q101H;
    logic [`MINI_CORE_XLEN-1:0]    regRdData2Q101H;
    logic [`MINI_CORE_XLEN-1:0]    aluOutQ102H;

    mini_core_ctrl i_mini_core_ctrl (
        .Clock            (Clock),
        .rstN             (rstN),
        .InstValidQ101H   (InstValidQ101H),
        .InstructionQ101H (InstructionQ101H),
        .RegRdData1Q101H  (regRdData1Q101H),
        .RegRdData2Q101H  (regRdData2Q101H),
        .CtrlRf           (ctrlRf),
        .CtrlAlu          (ctrlAlu)
    );

    mini_core_rf i_mini_core_rf (
        .Clock           (Clock),
        .rstN            (rstN),
        .CtrlRf          (ctrlRf),
        .WrDataQ102H     (aluOutQ102H),  // Same value leaves on Wb
        .RegRdData1Q101H (regRdData1Q101H),
        .RegRdData2Q101H (regRdData2Q101H)
    );

    mini_core_exe i_mini_core_exe (
        .Clock       (Clock),
        .rstN        (rstN),
        .CtrlAlu     (ctrlAlu),
        .AluOutQ102H (aluOutQ102H)
    );

    // x0 writes still report valid here
    assign Wb.WbValid = ctrlRf.RegWrEnQ102H;
    assign Wb.RegDst  = ctrlRf.RegDstQ102H;
    assign Wb.WbData  = aluOutQ102H;

endmodule

`default_nettype wire

//--- design/mini_core_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "mini_core_defines.svh"

module mini_core_alu (
    input  wire mini_core_isa_pkg::t_alu_op AluOp,
    input  wire logic [`MINI_CORE_XLEN-1:0] AluIn1,
    input  wire logic [`MINI_CORE_XLEN-1:0] AluIn2,
    output var  logic [`MINI_CORE_XLEN-1:0] AluOut
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = AluIn2[4:0];  // RV32 shift range
    assign ltSigned   = $signed(AluIn1) < $signed(AluIn2);
    assign ltUnsigned = AluIn1 < AluIn2;

    always_comb begin
        case (AluOp)
            mini_core_isa_pkg::ADD:  AluOut = AluIn1 + AluIn2;
            mini_core_isa_pkg::SUB:  AluOut = AluIn1 - AluIn2;
            mini_core_isa_pkg::SLL:  AluOut = AluIn1 << shamt;
            mini_core_isa_pkg::SLT:  AluOut = {{(`MINI_CORE_XLEN-1){1'b0}}, ltSigned};
            mini_core_isa_pkg::SLTU: AluOut = {{(`MINI_CORE_XLEN-1){1'b0}}, ltUnsigned};
            mini_core_isa_pkg::XOR:  AluOut = AluIn1 ^ AluIn2;
            mini_core_isa_pkg::SRL:  AluOut = AluIn1 >> shamt;
            mini_core_isa_pkg::SRA:  AluOut = $unsigned($signed(AluIn1) >>> shamt);
            mini_core_isa_pkg::OR:   AluOut = AluIn1 | AluIn2;
            mini_core_isa_pkg::AND:  AluOut = AluIn1 & AluIn2;
            default:                 AluOut = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/mini_core_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mini_core_defines.svh"

module mini_core_ctrl (
    input  wire logic                           Clock,
    input  wire logic                           rstN,
    input  wire logic                           InstValidQ101H,
    input  wire mini_core_isa_pkg::t_instr      InstructionQ101H,
    input  wire logic [`MINI_CORE_XLEN-1:0]     RegRdData1Q101H,
    input  wire logic [`MINI_CORE_XLEN-1:0]     RegRdData2Q101H,
    output var  mini_core_pipe_pkg::t_ctrl_rf   CtrlRf,
    output var  mini_core_pipe_pkg::t_ctrl_alu  CtrlAlu
);

    mini_core_isa_pkg::t_opcode      opcodeQ101H;
    logic [6:0]                      funct7Q101H;
    logic [2:0]                      funct3Q101H;
    logic [`MINI_CORE_XLEN-1:0]      immQ101H;
    mini_core_isa_pkg::t_alu_op      aluOpQ101H;
    logic                            legalQ101H;
    logic                            regWrEnQ101H;
    logic [`MINI_CORE_REG_IDX_W-1:0] regDstQ102H;
    logic                            regWrEnQ102H;

    assign opcodeQ101H = InstructionQ101H.r.opcode;
    assign funct7Q101H = InstructionQ101H.r.funct7;
    assign funct3Q101H = InstructionQ101H.r.funct3;

    // Sign-extended I-type immediate
    assign immQ101H = {{(`MINI_CORE_XLEN-12){InstructionQ101H.i.imm[11]}},
                       InstructionQ101H.i.imm};

    always_comb begin
        legalQ101H = 1'b1;
        case ({funct3Q101H, funct7Q101H, opcodeQ101H}) inside
            {mini_core_isa_pkg::F3_ADD, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::ADD;
            {mini_core_isa_pkg::F3_ADD, mini_core_isa_pkg::F7_ALT, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::SUB;
            {mini_core_isa_pkg::F3_SLL, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::SLL;
            {mini_core_isa_pkg::F3_SLT, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::SLT;
            {mini_core_isa_pkg::F3_SLTU, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::SLTU;
            {mini_core_isa_pkg::F3_XOR, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::XOR;
            {mini_core_isa_pkg::F3_SR, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::SRL;
            {mini_core_isa_pkg::F3_SR, mini_core_isa_pkg::F7_ALT, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::SRA;
            {mini_core_isa_pkg::F3_OR, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::OR;
            {mini_core_isa_pkg::F3_AND, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::R_OP}:
                aluOpQ101H = mini_core_isa_pkg::AND;
            // funct7 is immediate bits here, except for shifts
            {mini_core_isa_pkg::F3_ADD, 7'b???????, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::ADD;
            {mini_core_isa_pkg::F3_SLT, 7'b???????, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::SLT;
            {mini_core_isa_pkg::F3_SLTU, 7'b???????, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::SLTU;
            {mini_core_isa_pkg::F3_XOR, 7'b???????, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::XOR;
            {mini_core_isa_pkg::F3_OR, 7'b???????, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::OR;
            {mini_core_isa_pkg::F3_AND, 7'b???????, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::AND;
            {mini_core_isa_pkg::F3_SLL, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::SLL;
            {mini_core_isa_pkg::F3_SR, mini_core_isa_pkg::F7_BASE, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::SRL;
            {mini_core_isa_pkg::F3_SR, mini_core_isa_pkg::F7_ALT, mini_core_isa_pkg::I_OP}:
                aluOpQ101H = mini_core_isa_pkg::SRA;
            default: begin
                aluOpQ101H = mini_core_isa_pkg::ADD;  // Illegal, no writeback
                legalQ101H = 1'b0;
            end
        endcase
    end

    assign regWrEnQ101H = InstValidQ101H && legalQ101H;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            regDstQ102H  <= '0;
            regWrEnQ102H <= 1'b0;
        end else begin
            regDstQ102H  <= InstructionQ101H.r.rd;
            regWrEnQ102H <= regWrEnQ101H;
        end
    end

    assign CtrlRf.RegSrc1Q101H = InstructionQ101H.r.rs1;
    assign CtrlRf.RegSrc2Q101H = InstructionQ101H.r.rs2;
    assign CtrlRf.RegDstQ102H  = regDstQ102H;
    assign CtrlRf.RegWrEnQ102H = regWrEnQ102H;

    assign CtrlAlu.AluOpQ101H  = aluOpQ101H;
    assign CtrlAlu.AluIn1Q101H = RegRdData1Q101H;
    assign CtrlAlu.AluIn2Q101H = (opcodeQ101H == mini_core_isa_pkg::I_OP) ? immQ101H
                                                                         : RegRdData2Q101H;

endmodule

`default_nettype wire

//--- design/mini_core_exe.sv
`timescale 1ns/10ps
`default_nettype none

`include "mini_core_defines.svh"

module mini_core_exe (
    input  wire logic                          Clock,
    input  wire logic                          rstN,
    input  wire mini_core_pipe_pkg::t_ctrl_alu CtrlAlu,
    output var  logic [`MINI_CORE_XLEN-1:0]    AluOutQ102H
);

    logic [`MINI_CORE_XLEN-1:0] aluOutQ101H;

    mini_core_alu i_mini_core_alu (
        .AluOp  (CtrlAlu.AluOpQ101H),
        .AluIn1 (CtrlAlu.AluIn1Q101H),
        .AluIn2 (CtrlAlu.AluIn2Q101H),
        .AluOut (aluOutQ101H)
    );

    // Result stage register
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            AluOutQ102H <= '0;
        end else begin
            AluOutQ102H <= aluOutQ101H;
        end
    end

endmodule

`default_nettype wire

//--- design/mini_core_isa_pkg.sv
`default_nettype none

`include "mini_core_defines.svh"

package mini_core_isa_pkg;

    typedef enum logic [6:0] {
        R_OP = 7'b0110011,  // Register-register arithmetic
        I_OP = 7'b0010011   // Register-immediate arithmetic
    } t_opcode;

    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD/SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL/SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } t_alu_op;

    typedef struct packed {
        logic [6:0]                      funct7;
        logic [`MINI_CORE_REG_IDX_W-1:0] rs2;
        logic [`MINI_CORE_REG_IDX_W-1:0] rs1;
        logic [2:0]                      funct3;
        logic [`MINI_CORE_REG_IDX_W-1:0] rd;
        t_opcode                         opcode;
    } t_instr_r;

    typedef struct packed {
        logic [11:0]                     imm;
        logic [`MINI_CORE_REG_IDX_W-1:0] rs1;
        logic [2:0]                      funct3;
        logic [`MINI_CORE_REG_IDX_W-1:0] rd;
        t_opcode                         opcode;
    } t_instr_i;

    // One instruction word, two field layouts
    typedef union packed {
        t_instr_r r;
        t_instr_i i;
    } t_instr;

endpackage

`default_nettype wire

//--- design/mini_core_pipe_pkg.sv
`default_nettype none

`include "mini_core_defines.svh"

package mini_core_pipe_pkg;

    // Read ports in Q101H, write port in Q102H
    typedef struct packed {
        logic [`MINI_CORE_REG_IDX_W-1:0] RegSrc1Q101H;
        logic [`MINI_CORE_REG_IDX_W-1:0] RegSrc2Q101H;
        logic [`MINI_CORE_REG_IDX_W-1:0] RegDstQ102H;
        logic                            RegWrEnQ102H;
    } t_ctrl_rf;

    typedef struct packed {
        mini_core_isa_pkg::t_alu_op AluOpQ101H;
        logic [`MINI_CORE_XLEN-1:0] AluIn1Q101H;
        logic [`MINI_CORE_XLEN-1:0] AluIn2Q101H;  // Register or immediate
    } t_ctrl_alu;

    typedef struct packed {
        logic                            WbValid;
        logic [`MINI_CORE_REG_IDX_W-1:0] RegDst;
        logic [`MINI_CORE_XLEN-1:0]      WbData;
    } t_wb_q102;

endpackage

`default_nettype wire

//--- design/mini_core_rf.sv
`timescale 1ns/10ps
`default_nettype none

`include "mini_core_defines.svh"

module mini_core_rf (
    input  wire logic                         Clock,
    input  wire logic                         rstN,
    input  wire mini_core_pipe_pkg::t_ctrl_rf CtrlRf,
    input  wire logic [`MINI_CORE_XLEN-1:0]   WrDataQ102H,
    output var  logic [`MINI_CORE_XLEN-1:0]   RegRdData1Q101H,
    output var  logic [`MINI_CORE_XLEN-1:0]   RegRdData2Q101H
);

    logic [`MINI_CORE_XLEN-1:0] regs [`MINI_CORE_REG_NUM-1:1];  // No storage for x0

    // x0 first, then the write in flight, then the array
    function automatic logic [`MINI_CORE_XLEN-1:0] readReg(
        input logic [`MINI_CORE_REG_IDX_W-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end else if (CtrlRf.RegWrEnQ102H && (idx == CtrlRf.RegDstQ102H)) begin
            return WrDataQ102H;
        end else begin
            return regs[idx];
        end
    endfunction

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `MINI_CORE_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (CtrlRf.RegWrEnQ102H && (CtrlRf.RegDstQ102H != '0)) begin
            regs[CtrlRf.RegDstQ102H] <= WrDataQ102H;
        end
    end

    always_comb begin
        RegRdData1Q101H = readReg(CtrlRf.RegSrc1Q101H);
        RegRdData2Q101H = readReg(CtrlRf.RegSrc2Q101H);
    end

endmodule

`default_nettype wire

//--- include/mini_core_defines.svh
`ifndef MINI_CORE_DEFINES_SVH
`define MINI_CORE_DEFINES_SVH

// Datapath and instruction word width
`define MINI_CORE_XLEN 32

// Architectural register count, x0 included
`define MINI_CORE_REG_NUM 32

// Bits needed to index one register
`define MINI_CORE_REG_IDX_W 5

`endif

//--- verification/mini_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mini_core_defines.svh"

module mini_core_tb;

    localparam int NumRandom   = 2000;
    localparam int WaitTimeout = 8;  // Cycles allowed for one writeback

    logic                            clock;
    logic                            rstN;
    logic                            instValid;
    mini_core_isa_pkg::t_instr       instruction;
    mini_core_pipe_pkg::t_wb_q102    wb;

    logic [`MINI_CORE_XLEN-1:0]      modelRegs [0:`MINI_CORE_REG_NUM-1];
    logic                            pendValid;  // Expected writeback slot
    logic [`MINI_CORE_REG_IDX_W-1:0] pendRd;
    logic [`MINI_CORE_XLEN-1:0]      pendData;
    logic [`MINI_CORE_REG_IDX_W-1:0] lastRd;
    int                              mismatchCount;
    int                              timeoutCount;

    mini_core i_mini_core (
        .Clock            (clock),
        .rstN             (rstN),
        .InstValidQ101H   (instValid),
        .InstructionQ101H (instruction),
        .Wb               (wb)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, mini_core_isa_pkg::R_OP};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, mini_core_isa_pkg::I_OP};
    endfunction

    // Returns 1 for a legal encoding
    function automatic logic modelExec(input logic [31:0] word, output logic [31:0] result);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  shamt;
        logic        isImm;
        logic        legal;
        opc    = word[6:0];
        f3     = word[14:12];
        f7     = word[31:25];
        result = '0;
        isImm  = (opc == mini_core_isa_pkg::I_OP);
        if (!isImm && (opc != mini_core_isa_pkg::R_OP)) begin
            return 1'b0;
        end
        a     = modelRegs[word[19:15]];
        b     = isImm ? {{20{word[31]}}, word[31:20]} : modelRegs[word[24:20]];
        shamt = b[4:0];
        legal = 1'b1;
        case (f3)
            3'b000: begin
                if (isImm || (f7 == 7'h00)) result = a + b;
                else if (f7 == 7'h20) result = a - b;
                else legal = 1'b0;
            end
            3'b001: begin
                if (f7 == 7'h00) result = a << shamt;
                else legal = 1'b0;
            end
            3'b010: begin
                // Differing signs decide alone
                if (isImm || (f7 == 7'h00)) result = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                else legal = 1'b0;
            end
            3'b011: begin
                if (isImm || (f7 == 7'h00)) result = {31'b0, a < b};
                else legal = 1'b0;
            end
            3'b100: begin
                if (isImm || (f7 == 7'h00)) result = a ^ b;
                else legal = 1'b0;
            end
            3'b101: begin
                if (f7 == 7'h00) result = a >> shamt;
                else if (f7 == 7'h20) result = (a >> shamt) |
                                               ({32{a[31]}} & ~(32'hffff_ffff >> shamt));
                else legal = 1'b0;
            end
            3'b110: begin
                if (isImm || (f7 == 7'h00)) result = a | b;
                else legal = 1'b0;
            end
            default: begin
                if (isImm || (f7 == 7'h00)) result = a & b;
                else legal = 1'b0;
            end
        endcase
        return legal;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        int          f7Sel;
        kind  = $urandom_range(9, 0);
        rd    = 5'($urandom_range(31, 0));
        rs1   = 5'($urandom_range(31, 0));
        rs2   = 5'($urandom_range(31, 0));
        if ($urandom_range(15, 0) == 0) rd = '0;
        if ($urandom_range(2, 0) == 0) rs1 = lastRd;  // Dependent on the previous result
        if ($urandom_range(3, 0) == 0) rs2 = lastRd;
        f3    = 3'($urandom_range(7, 0));
        f7Sel = $urandom_range(7, 0);
        if (f7Sel < 4) f7 = 7'h00;
        else if (f7Sel < 6) f7 = 7'h20;
        else f7 = 7'($urandom_range(127, 0));
        if (kind < 5) begin
            return encodeR(f7, rs2, rs1, f3, rd);
        end else if (kind < 9) begin
            if ((f3 == 3'b001) || (f3 == 3'b101)) imm = {f7, rs2};  // Shift-immediate form
            else imm = 12'($urandom);
            return encodeI(imm, rs1, f3, rd);
        end
        return $urandom;  // Mostly foreign opcodes
    endfunction

    task automatic checkWb();
        assert (wb.WbValid == pendValid) else begin
            $display("ERR %0t: WbValid expected %0b, got %0b", $time, pendValid, wb.WbValid);
            mismatchCount++;
        end
        if (pendValid) begin
            assert ((wb.RegDst == pendRd) && (wb.WbData == pendData)) else begin
                $display("ERR %0t: writeback expected x%0d=%h, got x%0d=%h",
                         $time, pendRd, pendData, wb.RegDst, wb.WbData);
                mismatchCount++;
            end
        end
    endtask

    task automatic issue(input logic valid, input logic [31:0] word);
        logic        legal;
        logic [31:0] res;
        legal       = modelExec(word, res);
        instValid   = valid;
        instruction = word;
        pendValid   = valid && legal;
        pendRd      = word[11:7];
        pendData    = res;
        if (pendValid && (pendRd != '0)) modelRegs[pendRd] = res;
        if (pendValid) lastRd = pendRd;
    endtask

    // Result checked one edge after issue
    task automatic stepCycle(input logic valid, input logic [31:0] word);
        checkWb();
        issue(valid, word);
        @(posedge clock);
        #1;
    endtask

    task automatic issueAndWait(input logic [31:0] word);
        int cycles;
        cycles = 0;
        checkWb();
        issue(1'b1, word);
        do begin
            @(posedge clock);
            #1;
            instValid = 1'b0;
            cycles++;
        end while (!wb.WbValid && (cycles < WaitTimeout));
        if (!wb.WbValid) begin
            $display("Timeout: no writeback within %0d cycles at %0t", WaitTimeout, $time);
            timeoutCount++;
        end else begin
            assert (cycles == 1) else begin
                $display("ERR %0t: writeback latency expected 1, got %0d", $time, cycles);
                mismatchCount++;
            end
        end
    endtask

    initial begin
        clock         = 1'b0;
        rstN          = 1'b0;
        instValid     = 1'b0;
        instruction   = '0;
        pendValid     = 1'b0;
        pendRd        = '0;
        pendData      = '0;
        lastRd        = '0;
        mismatchCount = 0;
        timeoutCount  = 0;
        void'($urandom(32'habf456e3));
        for (int r = 0; r < `MINI_CORE_REG_NUM; r++) begin
            modelRegs[r] = '0;
        end

        for (int c = 0; c < 16; c++) begin
            @(posedge clock);
            #1;
            assert (!wb.WbValid) else begin
                $display("ERR %0t: WbValid high during reset", $time);
                mismatchCount++;
            end
        end
        rstN = 1'b1;
        stepCycle(1'b0, '0);
        stepCycle(1'b0, '0);

        // ADDI xr, xr, 0 reads every register once after reset
        for (int r = 1; r < `MINI_CORE_REG_NUM; r++) begin
            issueAndWait(encodeI(12'h000, 5'(r), 3'b000, 5'(r)));
        end

        stepCycle(1'b1, encodeI(12'h123, 5'd0, 3'b000, 5'd7));
        stepCycle(1'b1, encodeI(12'h001, 5'd7, 3'b000, 5'd0));  // Write to x0
        stepCycle(1'b1, encodeR(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));
        stepCycle(1'b1, encodeI(12'hfff, 5'd7, 3'b000, 5'd9));
        stepCycle(1'b1, encodeR(7'h20, 5'd9, 5'd7, 3'b000, 5'd10));  // SUB on bypass
        stepCycle(1'b0, encodeI(12'h055, 5'd0, 3'b000, 5'd7));
        stepCycle(1'b1, encodeR(7'h01, 5'd7, 5'd7, 3'b000, 5'd7));  // Bad funct7
        stepCycle(1'b1, encodeI(12'h000, 5'd7, 3'b000, 5'd11));

        for (int n = 0; n < NumRandom; n++) begin
            stepCycle($urandom_range(9, 0) != 0, randomWord());
        end
        checkWb();

        $display("Summary: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if ((mismatchCount == 0) && (timeoutCount == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
